// ==== design/bram_pkt_writer.sv ====
`timescale 1ns/100ps

module bram_pkt_writer
    import pkt_format_pkg::*;
#(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write_en,
    input  logic              clear,
    input  logic [ADDR_W-1:0] depth,
    input  logic              parity_last,
    input  pkt_word_u         sel_word,
    output logic              rd_pulse,
    output logic              write_done,
    output logic              bram_we,
    output logic [ADDR_W-1:0] bram_addr,
    output logic [DATA_W-1:0] bram_din
);

    logic [ADDR_W-1:0] cnt;
    logic              last_rd;

    // write sequence counter
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            cnt <= '0;
        end else if (write_en) begin
            cnt <= cnt + ADDR_W'(1);
        end
    end

    // counts 1 .. depth+1: header, then depth payload words
    assign rd_pulse   = (cnt != '0) && (cnt <= depth + ADDR_W'(1));
    assign last_rd    = (cnt == depth + ADDR_W'(1));
    // a few spare cycles after the last write
    assign write_done = (cnt == depth + ADDR_W'(5));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bram_we <= 1'b0;
        end else begin
            bram_we <= rd_pulse;
        end
    end

    // word read at count n lands at n-1
    always_ff @(posedge clk) begin
        if (rd_pulse) begin
            bram_din <= sel_word.data;
            // last word overwrites the header for correct parity
            if (parity_last && last_rd) begin
                bram_addr <= '0;
            end else begin
                bram_addr <= cnt - ADDR_W'(1);
            end
        end
    end

    // each packet starts from a cleared counter
    a_cnt_cleared: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(write_en) |-> cnt == '0);

endmodule

// ==== design/pkt_ctrl_pkg.sv ====
package pkt_ctrl_pkg;

    // packet sequencer states
    typedef enum logic [2:0] {
        idle        = 3'd0,
        grant       = 3'd1,
        read_header = 3'd2,
        write_bram  = 3'd3,
        wait_net    = 3'd4
    } pkt_state_t;

    // granted source fifo
    typedef enum logic [1:0] {
        none  = 2'd0,
        decoy = 2'd1,
        er    = 2'd2,
        pa    = 2'd3
    } src_sel_t;

endpackage

// ==== design/pkt_format_pkg.sv ====
package pkt_format_pkg;

    // width of one fifo or bram word
    localparam int WORD_W = 32;

    // packet kind, header bits 31:28
    typedef enum logic [3:0] {
        a2b_decoy_info     = 4'h1,
        a2b_er_syndrome    = 4'h2,
        a2b_correct_parity = 4'h3,
        a2b_pa_seed        = 4'h4
    } pkt_type_t;

    // length code, header bits 27:24
    typedef enum logic [3:0] {
        len_257  = 4'h1,
        len_514  = 4'h2,
        len_771  = 4'h3,
        len_1028 = 4'h4
    } pkt_len_code_t;

    // header word layout, msb first
    typedef struct packed {
        pkt_type_t     pkt_type;
        pkt_len_code_t len_code;
        // payload depth, only for len_257
        logic [8:0]    short_depth;
        // last word replaces the header
        logic          par_last;
        logic [13:0]   rsvd;
    } pkt_hdr_t;

    // same fifo word, header view or raw payload view
    typedef union packed {
        pkt_hdr_t          hdr;
        logic [WORD_W-1:0] data;
    } pkt_word_u;

    // message sizes reported to the network side
    localparam int MSG_SIZE_257  = 257;
    localparam int MSG_SIZE_514  = 514;
    localparam int MSG_SIZE_771  = 771;
    localparam int MSG_SIZE_1028 = 1028;

    // payload depths of the full-length codes
    localparam int DEPTH_514  = 512;
    localparam int DEPTH_771  = 768;
    localparam int DEPTH_1028 = 1024;

endpackage

// ==== design/pkt_header_decode.sv ====
`timescale 1ns/100ps

module pkt_header_decode
    import pkt_format_pkg::*;
#(
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hdr_en,
    input  logic              clear,
    input  pkt_word_u         sel_word,
    output logic [ADDR_W-1:0] depth,
    output logic [ADDR_W-1:0] msg_size,
    output logic              parity_last
);

    pkt_hdr_t hdr_q;

    // front word of the granted fifo is the header
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            hdr_q <= '0;
        end else if (hdr_en) begin
            hdr_q <= sel_word.hdr;
        end
    end

    // length code to payload depth and message size
    always_comb begin
        case (hdr_q.len_code)
            len_257: begin
                depth    = ADDR_W'(hdr_q.short_depth);
                msg_size = ADDR_W'(MSG_SIZE_257);
            end
            len_514: begin
                depth    = ADDR_W'(DEPTH_514);
                msg_size = ADDR_W'(MSG_SIZE_514);
            end
            len_771: begin
                depth    = ADDR_W'(DEPTH_771);
                msg_size = ADDR_W'(MSG_SIZE_771);
            end
            // len_1028 and unknown codes, longest packet
            default: begin
                depth    = ADDR_W'(DEPTH_1028);
                msg_size = ADDR_W'(MSG_SIZE_1028);
            end
        endcase
    end

    // flag only counts for correct-parity packets
    assign parity_last = (hdr_q.pkt_type == a2b_correct_parity) && hdr_q.par_last;

endmodule

// ==== design/pkt_seq_fsm.sv ====
`timescale 1ns/100ps

module pkt_seq_fsm
    import pkt_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic busy_net2pp,
    input  logic any_valid,
    input  logic write_done,
    output logic grant_en,
    output logic hdr_en,
    output logic write_en,
    output logic clear,
    output logic busy_pp2net,
    output logic msg_stored
);

    pkt_state_t state;
    pkt_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                // network must be free and some source must hold a packet
                if (!busy_net2pp && any_valid) begin
                    state_nxt = grant;
                end
            end
            grant: begin
                state_nxt = read_header;
            end
            read_header: begin
                state_nxt = write_bram;
            end
            write_bram: begin
                if (write_done) begin
                    state_nxt = wait_net;
                end
            end
            wait_net: begin
                // network has taken the message
                if (busy_net2pp) begin
                    state_nxt = idle;
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    // one-hot controls straight from the state
    assign grant_en    = (state == grant);
    assign hdr_en      = (state == read_header);
    assign write_en    = (state == write_bram);
    assign clear       = (state == idle);
    assign busy_pp2net = grant_en || hdr_en || write_en;
    assign msg_stored  = (state == wait_net);

    // writer only finishes while the sequencer is writing
    a_done_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        write_done |-> write_en);

    // a granted packet still has a source to read from
    a_grant_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        grant_en |-> any_valid);

endmodule

// ==== design/src_fifo_arbiter.sv ====
`timescale 1ns/100ps

module src_fifo_arbiter
    import pkt_format_pkg::*;
    import pkt_ctrl_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              grant_en,
    input  logic              clear,
    input  logic              rd_pulse,
    input  logic              decoy_valid,
    input  logic              er_valid,
    input  logic              pa_valid,
    input  logic [DATA_W-1:0] decoy_dout,
    input  logic [DATA_W-1:0] er_dout,
    input  logic [DATA_W-1:0] pa_dout,
    output logic              decoy_rd_en,
    output logic              er_rd_en,
    output logic              pa_rd_en,
    output logic              any_valid,
    output pkt_word_u         sel_word
);

    src_sel_t grant_sel;

    // fixed priority decoy > er > pa, held for the whole packet
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            grant_sel <= none;
        end else if (grant_en) begin
            if (decoy_valid) begin
                grant_sel <= decoy;
            end else if (er_valid) begin
                grant_sel <= er;
            end else if (pa_valid) begin
                grant_sel <= pa;
            end else begin
                grant_sel <= none;
            end
        end
    end

    assign any_valid = decoy_valid || er_valid || pa_valid;

    // pop only the granted fifo
    assign decoy_rd_en = rd_pulse && (grant_sel == decoy);
    assign er_rd_en    = rd_pulse && (grant_sel == er);
    assign pa_rd_en    = rd_pulse && (grant_sel == pa);

    // front word of the granted fifo
    always_comb begin
        case (grant_sel)
            decoy:   sel_word.data = decoy_dout;
            er:      sel_word.data = er_dout;
            pa:      sel_word.data = pa_dout;
            default: sel_word.data = '0;
        endcase
    end

    // writer pacing must never underrun the granted source
    a_no_empty_read: assert property (@(posedge clk) disable iff (!rst_n)
        !((decoy_rd_en && !decoy_valid) || (er_rd_en && !er_valid) || (pa_rd_en && !pa_valid)));

endmodule

// ==== design/tx_pkt_builder.sv ====
`timescale 1ns/100ps

module tx_pkt_builder
    import pkt_format_pkg::*;
#(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              rst_n,
    // network handoff
    input  logic              busy_net2pp,
    output logic              busy_pp2net,
    output logic              msg_stored,
    output logic [ADDR_W-1:0] msg_size,
    // decoy fifo
    input  logic [DATA_W-1:0] decoy_dout,
    input  logic              decoy_valid,
    output logic              decoy_rd_en,
    // error reconciliation fifo
    input  logic [DATA_W-1:0] er_dout,
    input  logic              er_valid,
    output logic              er_rd_en,
    // privacy amplification fifo
    input  logic [DATA_W-1:0] pa_dout,
    input  logic              pa_valid,
    output logic              pa_rd_en,
    // transmit bram write port
    output logic              bram_we,
    output logic [ADDR_W-1:0] bram_addr,
    output logic [DATA_W-1:0] bram_din
);

    logic              grant_en;
    logic              hdr_en;
    logic              write_en;
    logic              clear;
    logic              any_valid;
    logic              write_done;
    logic              rd_pulse;
    logic              parity_last;
    logic [ADDR_W-1:0] depth;
    pkt_word_u         sel_word;

    // sequencer and network handoff
    pkt_seq_fsm u_pkt_seq_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .busy_net2pp (busy_net2pp),
        .any_valid   (any_valid),
        .write_done  (write_done),
        .grant_en    (grant_en),
        .hdr_en      (hdr_en),
        .write_en    (write_en),
        .clear       (clear),
        .busy_pp2net (busy_pp2net),
        .msg_stored  (msg_stored)
    );

    src_fifo_arbiter #(
        .DATA_W (DATA_W)
    ) u_src_fifo_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .grant_en    (grant_en),
        .clear       (clear),
        .rd_pulse    (rd_pulse),
        .decoy_valid (decoy_valid),
        .er_valid    (er_valid),
        .pa_valid    (pa_valid),
        .decoy_dout  (decoy_dout),
        .er_dout     (er_dout),
        .pa_dout     (pa_dout),
        .decoy_rd_en (decoy_rd_en),
        .er_rd_en    (er_rd_en),
        .pa_rd_en    (pa_rd_en),
        .any_valid   (any_valid),
        .sel_word    (sel_word)
    );

    pkt_header_decode #(
        .ADDR_W (ADDR_W)
    ) u_pkt_header_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .hdr_en      (hdr_en),
        .clear       (clear),
        .sel_word    (sel_word),
        .depth       (depth),
        .msg_size    (msg_size),
        .parity_last (parity_last)
    );

    bram_pkt_writer #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_bram_pkt_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (write_en),
        .clear       (clear),
        .depth       (depth),
        .parity_last (parity_last),
        .sel_word    (sel_word),
        .rd_pulse    (rd_pulse),
        .write_done  (write_done),
        .bram_we     (bram_we),
        .bram_addr   (bram_addr),
        .bram_din    (bram_din)
    );

endmodule

// ==== flist.f ====
design/pkt_format_pkg.sv
design/pkt_ctrl_pkg.sv
design/pkt_seq_fsm.sv
design/src_fifo_arbiter.sv
design/pkt_header_decode.sv
design/bram_pkt_writer.sv
design/tx_pkt_builder.sv
verification/tb_tx_pkt_builder.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tx_pkt_builder testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_tx_pkt_builder -Mdir obj_dir -o sim_tx_pkt_builder -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/sim_tx_pkt_builder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi
if grep -qx "Test OK" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verification/pkt_input.txt ====
// columns (hex): source mask (bit0 decoy, bit1 er, bit2 pa), header word, busy delay,
// expected winner (1 decoy, 2 er, 3 pa), expected msg_size
1 11020000 3 1 101  // decoy alone, len_257 depth 4
2 21020000 2 2 101  // er alone
4 41020000 0 3 101  // pa alone, network answers at once
7 11030000 4 1 101  // all valid, decoy wins, depth 6
6 21030000 1 2 101  // er beats pa
5 41030000 2 1 101  // decoy beats pa
3 11030000 1 1 101  // decoy beats er
1 3102c000 2 1 101  // correct parity, flag set, depth 5
2 31028000 1 2 101  // correct parity, flag clear
4 2102c000 1 3 101  // flag set on another type
2 12000000 3 2 202  // len_514
4 47000000 2 3 404  // unknown length code
1 23000000 0 1 303  // len_771
3 3402c000 5 1 404  // len_1028 with last word on address 0
6 11020000 8 2 101  // slow network
0 00000000 0 0 000  // end of list

// ==== verification/tb_tx_pkt_builder.sv ====
`timescale 1ns/100ps

module tb_tx_pkt_builder
    import pkt_format_pkg::*;
();

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 11;
    localparam int MAX_PKTS = 16;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              busy_net2pp;
    logic              busy_pp2net;
    logic              msg_stored;
    logic [ADDR_W-1:0] msg_size;
    logic [DATA_W-1:0] decoy_dout;
    logic [DATA_W-1:0] er_dout;
    logic [DATA_W-1:0] pa_dout;
    logic              decoy_valid;
    logic              er_valid;
    logic              pa_valid;
    logic              decoy_rd_en;
    logic              er_rd_en;
    logic              pa_rd_en;
    logic              bram_we;
    logic [ADDR_W-1:0] bram_addr;
    logic [DATA_W-1:0] bram_din;

    // fifo contents and a copy of what was loaded, index 0 decoy, 1 er, 2 pa
    logic [DATA_W-1:0] fifo_q [3][$];
    logic [DATA_W-1:0] load_q [3][$];
    pkt_word_u         shadow [0:(1<<ADDR_W)-1];
    // five hex words per packet line
    logic [DATA_W-1:0] vec_mem [0:5*MAX_PKTS-1];
    logic [15:0]       lfsr_state;
    int                cycles;
    int                limit;
    int                err_cnt;
    int                chk_cnt;
    int                wr_cnt;
    int                pops [3];
    // outputs as seen at the falling edge
    logic              smp_stored;
    logic              smp_busy;
    logic [ADDR_W-1:0] smp_size;

    always #20 clk = ~clk;

    tx_pkt_builder #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_tx_pkt_builder (
        .clk         (clk),
        .rst_n       (rst_n),
        .busy_net2pp (busy_net2pp),
        .busy_pp2net (busy_pp2net),
        .msg_stored  (msg_stored),
        .msg_size    (msg_size),
        .decoy_dout  (decoy_dout),
        .decoy_valid (decoy_valid),
        .decoy_rd_en (decoy_rd_en),
        .er_dout     (er_dout),
        .er_valid    (er_valid),
        .er_rd_en    (er_rd_en),
        .pa_dout     (pa_dout),
        .pa_valid    (pa_valid),
        .pa_rd_en    (pa_rd_en),
        .bram_we     (bram_we),
        .bram_addr   (bram_addr),
        .bram_din    (bram_din)
    );

    // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per payload bit
    function automatic logic [DATA_W-1:0] lfsr_word();
        logic [DATA_W-1:0] w;
        int                b;
        w = '0;
        for (b = 0; b < DATA_W; b++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            w = {w[DATA_W-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // payload depth from the length code
    function automatic int hdr_depth(input pkt_word_u w);
        case (w.hdr.len_code)
            len_257: return int'(w.hdr.short_depth);
            len_514: return 512;
            len_771: return 768;
            default: return 1024;
        endcase
    endfunction

    function automatic logic hdr_parity(input pkt_word_u w);
        return (w.hdr.pkt_type == a2b_correct_parity) && w.hdr.par_last;
    endfunction

    function automatic string src_name(input int i);
        case (i)
            0:       return "decoy";
            1:       return "er";
            default: return "pa";
        endcase
    endfunction

    task automatic check_word(input string name, input pkt_word_u exp, input pkt_word_u act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t %s expected %h actual %h", $time, name, exp.data, act.data);
        end
    endtask

    task automatic check_count(input string name, input logic [ADDR_W-1:0] exp,
                               input logic [ADDR_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // fwft view: front word shown before any read
    task automatic drive_fifos();
        decoy_valid = (fifo_q[0].size() != 0);
        er_valid    = (fifo_q[1].size() != 0);
        pa_valid    = (fifo_q[2].size() != 0);
        decoy_dout  = decoy_valid ? fifo_q[0][0] : '0;
        er_dout     = er_valid ? fifo_q[1][0] : '0;
        pa_dout     = pa_valid ? fifo_q[2][0] : '0;
    endtask

    // sample at the falling edge, pop and drive just after the rising edge
    task automatic tick();
        logic [2:0] rd_vec;
        logic [2:0] val_vec;
        int         i;
        @(negedge clk);
        rd_vec  = {pa_rd_en, er_rd_en, decoy_rd_en};
        val_vec = {pa_valid, er_valid, decoy_valid};
        if ((rd_vec & ~val_vec) != 3'b000) begin
            err_cnt++;
            $display("error at %0t: read enable to an empty source fifo", $time);
        end
        if (busy_net2pp && (busy_pp2net || (|rd_vec))) begin
            err_cnt++;
            $display("error at %0t: packet activity while the network is busy", $time);
        end
        if (bram_we) begin
            shadow[bram_addr].data = bram_din;
            wr_cnt++;
        end
        smp_stored = msg_stored;
        smp_busy   = busy_pp2net;
        smp_size   = msg_size;
        @(posedge clk);
        #1;
        for (i = 0; i < 3; i++) begin
            if (rd_vec[i] && fifo_q[i].size() != 0) begin
                void'(fifo_q[i].pop_front());
                pops[i]++;
            end
        end
        drive_fifos();
    endtask

    task automatic run_packet(input int n, input logic [2:0] mask, input pkt_word_u hdr,
                              input int delay, input int win,
                              input logic [ADDR_W-1:0] exp_size);
        logic [DATA_W-1:0] w;
        int                d;
        int                i;
        int                k;
        int                err_before;
        logic              par;
        logic              started;
        d          = hdr_depth(hdr);
        par        = hdr_parity(hdr);
        err_before = err_cnt;
        // every masked source holds the header and its own payload
        for (i = 0; i < 3; i++) begin
            fifo_q[i].delete();
            load_q[i].delete();
            pops[i] = 0;
            if (mask[i]) begin
                fifo_q[i].push_back(hdr.data);
                load_q[i].push_back(hdr.data);
                for (k = 0; k < d; k++) begin
                    w = lfsr_word();
                    fifo_q[i].push_back(w);
                    load_q[i].push_back(w);
                end
            end
        end
        for (k = 0; k < (1 << ADDR_W); k++) begin
            shadow[k].data = 32'hA5A5_0000 ^ 32'(k);
        end
        wr_cnt = 0;
        drive_fifos();
        // sources valid but network still busy
        repeat (3) tick();
        busy_net2pp = 1'b0;
        started     = 1'b0;
        smp_stored  = 1'b0;
        while (!smp_stored) begin
            tick();
            if (smp_busy) begin
                started = 1'b1;
            end else if (started && !smp_stored) begin
                err_cnt++;
                $display("error at %0t: busy_pp2net dropped before msg_stored", $time);
            end
        end
        if (!started) begin
            err_cnt++;
            $display("error at %0t: busy_pp2net never rose for packet %0d", $time, n);
        end
        check_count("msg_size", exp_size, smp_size);
        check_flag("busy_pp2net", 1'b0, smp_busy);
        check_count("bram writes", ADDR_W'(d + 1), ADDR_W'(wr_cnt));
        if (par) begin
            // last payload word replaces the header
            check_word("bram[0]", load_q[win][d], shadow[0]);
            for (k = 1; k < d; k++) begin
                check_word($sformatf("bram[%0d]", k), load_q[win][k], shadow[k]);
            end
        end else begin
            for (k = 0; k <= d; k++) begin
                check_word($sformatf("bram[%0d]", k), load_q[win][k], shadow[k]);
            end
        end
        // winner drained, losers untouched
        for (i = 0; i < 3; i++) begin
            check_count($sformatf("%s pops", src_name(i)),
                        ADDR_W'((i == win) ? d + 1 : 0), ADDR_W'(pops[i]));
            check_count($sformatf("%s words left", src_name(i)),
                        ADDR_W'((i != win && mask[i]) ? d + 1 : 0), ADDR_W'(fifo_q[i].size()));
        end
        repeat (delay) begin
            tick();
            check_flag("msg_stored", 1'b1, smp_stored);
        end
        busy_net2pp = 1'b1;
        tick();
        check_flag("msg_stored", 1'b1, smp_stored);
        // size still held on the last stored cycle
        check_count("msg_size", exp_size, smp_size);
        tick();
        check_flag("msg_stored", 1'b0, smp_stored);
        $display("packet %0d src %s depth %0d parity %b: %s", n, src_name(win), d, par,
                 (err_cnt == err_before) ? "pass" : "fail");
    endtask

    // cycle budget, counted from the end of reset
    initial begin
        @(posedge rst_n);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, packet sequence did not complete", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int        n;
        int        i;
        int        sum;
        int        err_base;
        pkt_word_u h;
        rst_n       = 1'b0;
        busy_net2pp = 1'b1;
        lfsr_state  = 16'd15;
        cycles      = 0;
        limit       = 0;
        err_cnt     = 0;
        chk_cnt     = 0;
        wr_cnt      = 0;
        for (i = 0; i < 3; i++) begin
            fifo_q[i].delete();
            pops[i] = 0;
        end
        drive_fifos();
        $readmemh("verification/pkt_input.txt", vec_mem);
        // cycle budget from the packet list, mask 0 ends it
        n   = 0;
        sum = 0;
        while (n < MAX_PKTS && vec_mem[5*n] != 32'h0) begin
            h.data = vec_mem[5*n+1];
            sum    = sum + hdr_depth(h) + int'(vec_mem[5*n+2]) + 12;
            n++;
        end
        limit = 2 * sum;
        if (n == 0) begin
            err_cnt++;
            $display("error: no packets read from verification/pkt_input.txt");
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        err_base = err_cnt;
        @(negedge clk);
        check_flag("msg_stored", 1'b0, msg_stored);
        check_flag("busy_pp2net", 1'b0, busy_pp2net);
        check_flag("bram_we", 1'b0, bram_we);
        check_flag("decoy_rd_en", 1'b0, decoy_rd_en);
        check_flag("er_rd_en", 1'b0, er_rd_en);
        check_flag("pa_rd_en", 1'b0, pa_rd_en);
        $display("outputs after reset: %s", (err_cnt == err_base) ? "pass" : "fail");
        // back onto the drive point after the rising edge
        @(posedge clk);
        #1;
        for (i = 0; i < n; i++) begin
            run_packet(i, vec_mem[5*i][2:0], vec_mem[5*i+1], int'(vec_mem[5*i+2]),
                       int'(vec_mem[5*i+3]) - 1, vec_mem[5*i+4][ADDR_W-1:0]);
        end
        repeat (2) tick();
        $display("packets %0d  checks %0d  errors %0d", n, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
